//--- core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data word and program address widths
`define CORE_WORD_WIDTH 8
`define CORE_ADDR_WIDTH 8

// Stack depths in entries
`define CORE_DSTACK_DEPTH 16
`define CORE_CSTACK_DEPTH 4
`define CORE_LSTACK_DEPTH 3

// Interrupt lines and where their handlers live
`define CORE_IRQ_LINES 4
// Line n vectors to base + n * stride
`define CORE_VECTOR_BASE 192
`define CORE_VECTOR_STRIDE 8

`endif

//--- core_isa_pkg.sv
`default_nettype none

package core_isa_pkg;

  // One instruction per program memory byte
  typedef logic [7:0] instr_t;

  // Bit 7 set marks a literal push, the low bits are the value
  localparam int LIT_BIT = 7;

  // Opcodes with bit 7 clear, grouped loosely by function
  typedef enum logic [6:0] {
    OP_NOP      = 7'h00,
    OP_ADD      = 7'h01,
    OP_ADDC     = 7'h02,
    OP_SUB      = 7'h03,
    OP_AND      = 7'h04,
    OP_OR       = 7'h05,
    OP_XOR      = 7'h06,
    OP_DUP      = 7'h08,
    OP_DROP     = 7'h09,
    OP_SWAP     = 7'h0a,
    OP_JMP      = 7'h10,
    OP_CALL     = 7'h11,
    OP_RET      = 7'h12,
    OP_LOOP     = 7'h18,
    OP_BREAK    = 7'h19,
    OP_CONTINUE = 7'h1a,
    OP_IDX      = 7'h1b,
    OP_PUSHF    = 7'h20,
    OP_SETIE    = 7'h28,
    OP_WAIT     = 7'h29,
    OP_RECV     = 7'h2a,
    OP_SEND     = 7'h2b
  } opcode_t;

endpackage

`default_nettype wire

//--- core_uarch_pkg.sv
`default_nettype none

`include "core_config.svh"

package core_uarch_pkg;

  typedef logic [`CORE_WORD_WIDTH-1:0] word_t;
  typedef logic [`CORE_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`CORE_IRQ_LINES-1:0] irq_t;
  typedef logic [$clog2(`CORE_IRQ_LINES)-1:0] line_t;

  typedef struct packed {
    logic carry;
    logic overflow;
  } flags_t;

  // Pops are applied first, then the optional push
  typedef struct packed {
    logic [1:0] pops;
    logic       push;
    word_t      value;
  } dstack_op_t;

  typedef struct packed {
    addr_t ret_addr;
    logic  from_irq;
  } call_frame_t;

  typedef struct packed {
    addr_t beginning;
    addr_t ending;
    word_t total;
    word_t index;
  } loop_frame_t;

  typedef struct packed {
    logic  strobe;
    word_t data;
  } send_t;

endpackage

`default_nettype wire

//--- data_stack.sv
`default_nettype none

`include "core_config.svh"

module data_stack (
  input  logic                       clk,
  input  logic                       reset,
  input  core_uarch_pkg::dstack_op_t op,
  output core_uarch_pkg::word_t      top,
  output core_uarch_pkg::word_t      second
);

  localparam int PTR_WIDTH = $clog2(`CORE_DSTACK_DEPTH);

  typedef logic [PTR_WIDTH-1:0] ptr_t;

  core_uarch_pkg::word_t mem [`CORE_DSTACK_DEPTH];

  // Points at the current top entry and wraps around the array
  ptr_t ptr;
  ptr_t ptr_popped;
  ptr_t ptr_next;

  assign ptr_popped = ptr - ptr_t'(op.pops);
  assign ptr_next = op.push ? ptr_popped + ptr_t'(1) : ptr_popped;

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else begin
      ptr <= ptr_next;
    end
  end

  // A push after a single pop keeps the popped word just under the new top,
  // which is exactly an exchange when the pushed value is the old second
  always_ff @(posedge clk) begin
    if (op.push) begin
      mem[ptr_next] <= op.value;
      if (op.pops == 2'd1) begin
        mem[ptr_popped] <= mem[ptr];
      end
    end
  end

  assign top = mem[ptr];
  assign second = mem[ptr - ptr_t'(1)];

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

`include "core_config.svh"

module alu (
  input  logic                    clk,
  input  logic                    reset,
  input  core_isa_pkg::opcode_t   opcode,
  input  core_uarch_pkg::word_t   a,
  input  core_uarch_pkg::word_t   b,
  output core_uarch_pkg::word_t   result,
  output core_uarch_pkg::flags_t  flags
);

  localparam int W = `CORE_WORD_WIDTH;

  // One extra bit holds the carry out, or the borrow on a subtract
  logic [W:0] sum;
  logic       arith;
  core_uarch_pkg::flags_t flags_next;

  always_comb begin
    sum = '0;
    arith = 1'b1;
    result = b;
    case (opcode)
      core_isa_pkg::OP_ADD:  sum = {1'b0, a} + {1'b0, b};
      core_isa_pkg::OP_ADDC: sum = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, flags.carry};
      core_isa_pkg::OP_SUB:  sum = {1'b0, a} - {1'b0, b};
      default:               arith = 1'b0;
    endcase
    case (opcode)
      core_isa_pkg::OP_AND: result = a & b;
      core_isa_pkg::OP_OR:  result = a | b;
      core_isa_pkg::OP_XOR: result = a ^ b;
      default:              if (arith) result = sum[W-1:0];
    endcase
  end

  // Signed overflow: add of like signs, or subtract of unlike signs, flips the sign
  always_comb begin
    flags_next.carry = sum[W];
    if (opcode == core_isa_pkg::OP_SUB) begin
      flags_next.overflow = (a[W-1] != b[W-1]) && (sum[W-1] != a[W-1]);
    end else begin
      flags_next.overflow = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (arith) begin
      flags <= flags_next;
    end
  end

endmodule

`default_nettype wire

//--- frame_stack.sv
`default_nettype none

module frame_stack #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic             pop,
  input  logic [WIDTH-1:0] insert,
  output logic [WIDTH-1:0] top
);

  // Entry 0 is the top, deeper entries shift in behind it
  logic [WIDTH-1:0] frames [DEPTH];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        frames[i] <= '0;
      end
    end else if (push && pop) begin
      frames[0] <= insert;
    end else if (push) begin
      frames[0] <= insert;
      for (int i = 1; i < DEPTH; i++) begin
        frames[i] <= frames[i-1];
      end
    end else if (pop) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        frames[i] <= frames[i+1];
      end
      frames[DEPTH-1] <= '0;
    end
  end

  assign top = frames[0];

endmodule

`default_nettype wire

//--- loop_control.sv
`default_nettype none

`include "core_config.svh"

module loop_control (
  input  logic                  clk,
  input  logic                  reset,
  input  core_isa_pkg::opcode_t opcode,
  input  logic                  literal,
  input  core_uarch_pkg::addr_t pc,
  input  core_uarch_pkg::word_t top,
  input  core_uarch_pkg::word_t second,
  input  logic                  stall,
  output logic                  loop_redirect,
  output core_uarch_pkg::addr_t loop_target,
  output core_uarch_pkg::word_t index
);

  localparam int DEPTH_WIDTH = $clog2(`CORE_LSTACK_DEPTH + 1);

  core_uarch_pkg::loop_frame_t active;
  core_uarch_pkg::loop_frame_t outer;
  core_uarch_pkg::word_t       index_advance;
  // Number of frames saved on the loop stack
  logic [DEPTH_WIDTH-1:0] depth;
  logic op_loop;
  logic op_break;
  logic next_iter;
  logic last_iter;
  logic lstack_push;
  logic lstack_pop;

  assign op_loop = !literal && opcode == core_isa_pkg::OP_LOOP;
  assign op_break = !literal && opcode == core_isa_pkg::OP_BREAK;
  assign next_iter = (!literal && opcode == core_isa_pkg::OP_CONTINUE) || pc == active.ending;
  assign index_advance = active.index + 1'b1;
  assign last_iter = index_advance == active.total;

  assign lstack_push = !stall && op_loop;
  // The whole-program loop at depth 0 has nothing under it and just restarts
  assign lstack_pop = !stall && !op_loop && depth != '0 &&
                      (op_break || (next_iter && last_iter));
  assign loop_redirect = !stall && !op_loop && (op_break || next_iter);
  assign loop_target = (op_break || last_iter) ? active.ending + 1'b1 : active.beginning;
  assign index = active.index;

  frame_stack #(
    .WIDTH($bits(core_uarch_pkg::loop_frame_t)),
    .DEPTH(`CORE_LSTACK_DEPTH)
  ) lstack (
    .clk,
    .reset,
    .push(lstack_push),
    .pop(lstack_pop),
    .insert(active),
    .top(outer)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      active.beginning <= '0;
      active.ending <= '1;
      active.total <= '1;
      active.index <= '0;
      depth <= '0;
    end else if (lstack_push) begin
      // Body runs from the next address through the popped ending
      active.beginning <= pc + 1'b1;
      active.ending <= core_uarch_pkg::addr_t'(top);
      active.total <= second;
      active.index <= '0;
      if (depth != DEPTH_WIDTH'(`CORE_LSTACK_DEPTH)) begin
        depth <= depth + 1'b1;
      end
    end else if (lstack_pop) begin
      active <= outer;
      depth <= depth - 1'b1;
    end else if (!stall && (op_break || (next_iter && last_iter))) begin
      active.index <= '0;
    end else if (!stall && next_iter) begin
      active.index <= index_advance;
    end
  end

endmodule

`default_nettype wire

//--- interrupt_select.sv
`default_nettype none

`include "core_config.svh"

module interrupt_select (
  input  logic                  clk,
  input  logic                  reset,
  input  core_uarch_pkg::irq_t  irq_lines,
  input  logic                  set_enables,
  input  core_uarch_pkg::word_t enables_value,
  output logic                  pending,
  output core_uarch_pkg::line_t line,
  output core_uarch_pkg::addr_t vector
);

  core_uarch_pkg::irq_t enables;
  core_uarch_pkg::irq_t masked;

  // SETIE writes the mask from the low bits of the top of stack
  always_ff @(posedge clk) begin
    if (reset) begin
      enables <= '0;
    end else if (set_enables) begin
      enables <= enables_value[`CORE_IRQ_LINES-1:0];
    end
  end

  assign masked = irq_lines & enables;
  assign pending = |masked;

  // Scan downwards so the lowest set line wins
  always_comb begin
    line = '0;
    for (int i = `CORE_IRQ_LINES - 1; i >= 0; i--) begin
      if (masked[i]) begin
        line = core_uarch_pkg::line_t'(i);
      end
    end
  end

  assign vector = core_uarch_pkg::addr_t'(`CORE_VECTOR_BASE) +
                  core_uarch_pkg::addr_t'(line) *
                  core_uarch_pkg::addr_t'(`CORE_VECTOR_STRIDE);

endmodule

`default_nettype wire

//--- core0.sv
`default_nettype none

`include "core_config.svh"

module core0 (
  input  logic                   clk,
  input  logic                   reset,
  output core_uarch_pkg::addr_t  prog_addr,
  input  core_isa_pkg::instr_t   prog_data,
  input  core_uarch_pkg::irq_t   irq_lines,
  output core_uarch_pkg::send_t  send
);

  core_uarch_pkg::addr_t pc;
  core_uarch_pkg::addr_t pc_plain;
  core_uarch_pkg::addr_t pc_next;
  core_uarch_pkg::word_t top;
  core_uarch_pkg::word_t second;
  core_uarch_pkg::word_t alu_result;
  core_uarch_pkg::word_t loop_index;
  core_uarch_pkg::word_t send_data;
  core_uarch_pkg::addr_t loop_target;
  core_uarch_pkg::addr_t irq_vector;
  core_uarch_pkg::line_t irq_line;
  core_uarch_pkg::flags_t flags;
  core_uarch_pkg::dstack_op_t dstack_op;
  core_uarch_pkg::call_frame_t cstack_insert;
  core_uarch_pkg::call_frame_t cstack_top;
  core_isa_pkg::opcode_t opcode;
  core_isa_pkg::opcode_t alu_opcode;
  logic literal;
  logic op_ret;
  logic op_call;
  logic op_jump;
  logic op_send;
  logic op_block;
  logic stall;
  logic irq_pending;
  logic take_irq;
  logic irq_active;
  logic loop_redirect;
  logic send_strobe;

  assign literal = prog_data[core_isa_pkg::LIT_BIT];
  assign opcode = core_isa_pkg::opcode_t'(prog_data[core_isa_pkg::LIT_BIT-1:0]);
  assign alu_opcode = literal ? core_isa_pkg::OP_NOP : opcode;

  assign op_ret = !literal && opcode == core_isa_pkg::OP_RET;
  assign op_call = !literal && opcode == core_isa_pkg::OP_CALL;
  assign op_jump = op_call || (!literal && opcode == core_isa_pkg::OP_JMP);
  assign op_send = !literal && opcode == core_isa_pkg::OP_SEND;
  assign op_block = !literal && (opcode == core_isa_pkg::OP_WAIT ||
                                 opcode == core_isa_pkg::OP_RECV);

  // WAIT and RECV hold everything until an enabled line is high
  assign stall = op_block && !irq_pending;
  // RECV consumes the line itself instead of vectoring
  assign take_irq = irq_pending && !irq_active &&
                    !(!literal && opcode == core_isa_pkg::OP_RECV);

  always_comb begin
    dstack_op = '0;
    if (literal) begin
      dstack_op.push = 1'b1;
      dstack_op.value = core_uarch_pkg::word_t'(prog_data[core_isa_pkg::LIT_BIT-1:0]);
    end else begin
      case (opcode)
        core_isa_pkg::OP_ADD, core_isa_pkg::OP_ADDC, core_isa_pkg::OP_SUB,
        core_isa_pkg::OP_AND, core_isa_pkg::OP_OR, core_isa_pkg::OP_XOR: begin
          dstack_op.pops = 2'd2;
          dstack_op.push = 1'b1;
          dstack_op.value = alu_result;
        end
        core_isa_pkg::OP_DUP: begin
          dstack_op.push = 1'b1;
          dstack_op.value = top;
        end
        core_isa_pkg::OP_SWAP: begin
          dstack_op.pops = 2'd1;
          dstack_op.push = 1'b1;
          dstack_op.value = second;
        end
        core_isa_pkg::OP_DROP, core_isa_pkg::OP_JMP, core_isa_pkg::OP_CALL,
        core_isa_pkg::OP_SETIE, core_isa_pkg::OP_SEND: dstack_op.pops = 2'd1;
        core_isa_pkg::OP_LOOP: dstack_op.pops = 2'd2;
        core_isa_pkg::OP_IDX: begin
          dstack_op.push = 1'b1;
          dstack_op.value = loop_index;
        end
        core_isa_pkg::OP_PUSHF: begin
          dstack_op.push = 1'b1;
          dstack_op.value = core_uarch_pkg::word_t'({flags.carry, flags.overflow});
        end
        core_isa_pkg::OP_RECV: begin
          dstack_op.push = 1'b1;
          dstack_op.value = core_uarch_pkg::word_t'(irq_line);
        end
        default: ;
      endcase
    end
    if (stall) dstack_op = '0;
  end

  always_comb begin
    if (stall) pc_plain = pc;
    else if (op_ret) pc_plain = cstack_top.ret_addr;
    else if (op_jump) pc_plain = core_uarch_pkg::addr_t'(top);
    else if (loop_redirect) pc_plain = loop_target;
    else pc_plain = pc + 1'b1;
  end

  assign pc_next = take_irq ? irq_vector : pc_plain;
  assign cstack_insert.ret_addr = take_irq ? pc_plain : pc + 1'b1;
  assign cstack_insert.from_irq = take_irq;

  data_stack dstack (.clk, .reset, .op(dstack_op), .top, .second);

  alu alu_i (
    .clk, .reset, .opcode(alu_opcode), .a(second), .b(top), .result(alu_result), .flags
  );

  frame_stack #(
    .WIDTH($bits(core_uarch_pkg::call_frame_t)),
    .DEPTH(`CORE_CSTACK_DEPTH)
  ) cstack (
    .clk, .reset, .push(op_call || take_irq), .pop(op_ret),
    .insert(cstack_insert), .top(cstack_top)
  );

  loop_control loops (
    .clk, .reset, .opcode, .literal, .pc, .top, .second, .stall,
    .loop_redirect, .loop_target, .index(loop_index)
  );

  interrupt_select irqs (
    .clk, .reset, .irq_lines,
    .set_enables(!literal && opcode == core_isa_pkg::OP_SETIE),
    .enables_value(top), .pending(irq_pending), .line(irq_line), .vector(irq_vector)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      irq_active <= 1'b0;
      send_strobe <= 1'b0;
    end else begin
      pc <= pc_next;
      send_strobe <= op_send;
      if (take_irq) irq_active <= 1'b1;
      else if (op_ret && cstack_top.from_irq) irq_active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (op_send) send_data <= top;
  end

  assign prog_addr = pc;
  assign send.strobe = send_strobe;
  assign send.data = send_data;

endmodule

`default_nettype wire

//--- core0_assertions.sv
`default_nettype none

module core0_assertions (
  input logic                  clk,
  input logic                  reset,
  input core_uarch_pkg::addr_t prog_addr,
  input core_isa_pkg::instr_t  prog_data,
  input logic                  irq_pending,
  input core_uarch_pkg::send_t send
);

  // Read by the testbench at the end of the run
  int failures = 0;

  logic op_send;
  logic op_wait;

  assign op_send = prog_data == {1'b0, core_isa_pkg::OP_SEND};
  assign op_wait = prog_data == {1'b0, core_isa_pkg::OP_WAIT};

  strobe_low_after_reset: assert property (@(posedge clk) reset |=> !send.strobe)
    else begin
      $error("send strobe is high in the cycle after reset");
      failures++;
    end

  // The strobe is the registered image of a SEND one cycle earlier
  strobe_follows_send: assert property (
    @(posedge clk) disable iff (reset) send.strobe |-> $past(op_send))
    else begin
      $error("send strobe is high without a SEND in the previous cycle");
      failures++;
    end

  wait_holds_pc: assert property (
    @(posedge clk) disable iff (reset) (op_wait && !irq_pending) |=> $stable(prog_addr))
    else begin
      $error("program address moved while WAIT had no enabled line high");
      failures++;
    end

endmodule

`default_nettype wire

//--- tb_core0.sv
`default_nettype none

`include "core_config.svh"

module tb_core0;

  localparam int NUM_TESTS = 6;
  localparam int TEST_CYCLES = 400;

  logic clk;
  logic reset;
  core_uarch_pkg::addr_t prog_addr;
  core_isa_pkg::instr_t  prog_data;
  core_uarch_pkg::irq_t  irq_lines;
  core_uarch_pkg::send_t send;

  logic [7:0] prog_mem [256];
  // Expected send values, consumed in order as strobes are checked
  logic [7:0] exp_vals [128];
  int exp_head = 0;
  int exp_tail = 0;
  logic strobe_seen = 1'b0;

  int errors = 0;
  int fails_at_start;
  int tests_passed = 0;
  int tests_failed = 0;
  string test_name = "none";
  int fill_addr;
  logic [7:0] mstack [$];
  logic mc;
  logic mv;
  logic [31:0] lcg_state = 32'd53;

  core0 uut (.clk, .reset, .prog_addr, .prog_data, .irq_lines, .send);

  bind core0 core0_assertions chk (
    .clk, .reset, .prog_addr, .prog_data, .irq_pending, .send
  );

  assign prog_data = prog_mem[prog_addr];

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) strobe_seen <= !reset && send.strobe;

  // Move to the next expected value once the current strobe has been checked
  always @(negedge clk) begin
    if (strobe_seen && exp_head != exp_tail) exp_head = exp_head + 1;
  end

  send_matches: assert property (
    @(posedge clk) disable iff (reset)
    send.strobe |-> (exp_head != exp_tail && send.data == exp_vals[exp_head]))
    else begin
      if (exp_head == exp_tail) begin
        $display("%s: a send of %0d arrived when none was expected",
                 test_name, $sampled(send.data));
      end else begin
        $display("FAIL %s expected %0d actual %0d",
                 test_name, exp_vals[exp_head], $sampled(send.data));
      end
      errors++;
    end

  initial begin
    repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
    $display("Watchdog: the run took longer than %0d cycles and was stopped",
             NUM_TESTS * TEST_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Two's complement reading of an 8-bit value
  function automatic int as_signed(input int v);
    return (v >= 128) ? v - 256 : v;
  endfunction

  task automatic put(input logic [7:0] b);
    prog_mem[fill_addr[7:0]] = b;
    fill_addr++;
  endtask

  task automatic lit(input int v);
    put(8'h80 | 8'(v));
  endtask

  task automatic op(input core_isa_pkg::opcode_t o);
    put({1'b0, o});
  endtask

  task automatic org(input int a);
    fill_addr = a;
  endtask

  // Jump to itself forever
  task automatic halt_here();
    lit(fill_addr);
    op(core_isa_pkg::OP_JMP);
  endtask

  task automatic expect_send(input logic [7:0] v);
    exp_vals[exp_tail] = v;
    exp_tail++;
  endtask

  task automatic lit_and_model(input int v);
    lit(v);
    mstack.push_back(8'(v));
  endtask

  // Emits an opcode and applies it to the reference stack and flags
  task automatic op_and_model(input core_isa_pkg::opcode_t o);
    int a;
    int b;
    int r;
    int s;
    int cin;
    op(o);
    case (o)
      core_isa_pkg::OP_ADD, core_isa_pkg::OP_ADDC, core_isa_pkg::OP_SUB,
      core_isa_pkg::OP_XOR: begin
        b = mstack.pop_back();
        a = mstack.pop_back();
        if (o == core_isa_pkg::OP_XOR) begin
          mstack.push_back(8'(a ^ b));
        end else begin
          if (o == core_isa_pkg::OP_SUB) begin
            r = a - b;
            s = as_signed(a) - as_signed(b);
            // A borrow shows as an unsigned difference below zero
            mc = r < 0;
          end else begin
            cin = (o == core_isa_pkg::OP_ADDC) ? int'(mc) : 0;
            r = a + b + cin;
            s = as_signed(a) + as_signed(b) + cin;
            mc = r > 255;
          end
          // Signed result that does not fit in 8 bits
          mv = s > 127 || s < -128;
          mstack.push_back(8'(r));
        end
      end
      core_isa_pkg::OP_DUP: mstack.push_back(mstack[$]);
      core_isa_pkg::OP_DROP: void'(mstack.pop_back());
      core_isa_pkg::OP_SWAP: begin
        b = mstack.pop_back();
        a = mstack.pop_back();
        mstack.push_back(8'(b));
        mstack.push_back(8'(a));
      end
      core_isa_pkg::OP_SEND: expect_send(mstack.pop_back());
      core_isa_pkg::OP_PUSHF: mstack.push_back({6'b0, mc, mv});
      default: ;
    endcase
  endtask

  task automatic begin_test(input string name);
    // The core sits in reset while its program is replaced
    @(posedge clk);
    #2;
    reset = 1'b1;
    irq_lines = '0;
    test_name = name;
    fails_at_start = errors + uut.chk.failures;
    // Harmless literal pushes everywhere a program does not write
    for (int i = 0; i < 256; i++) begin
      prog_mem[i] = 8'h80 | 8'(i[6:0] ^ {6'b0, i[7]});
    end
    fill_addr = 0;
    mstack.delete();
    mc = 1'b0;
    mv = 1'b0;
  endtask

  task automatic release_reset();
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  task automatic wait_strobe(input string what);
    int n;
    n = 0;
    @(posedge clk);
    #2;
    while (!send.strobe && n < 100) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!send.strobe) begin
      $display("%s: gave up waiting for the %s", test_name, what);
      errors++;
    end
  endtask

  task automatic finish_test();
    int n;
    n = 0;
    while (exp_head != exp_tail && n < 300) begin
      @(posedge clk);
      n++;
    end
    if (exp_head != exp_tail) begin
      $display("%s: %0d expected sends never arrived", test_name, exp_tail - exp_head);
      errors++;
      exp_tail = exp_head;
    end
    // Extra cycles catch any stray send
    repeat (10) @(posedge clk);
    if (errors + uut.chk.failures == fails_at_start) begin
      $display("%s: passed", test_name);
      tests_passed++;
    end else begin
      $display("%s: failed", test_name);
      tests_failed++;
    end
  endtask

  task automatic arith_test();
    begin_test("arithmetic");
    lit_and_model(100);
    lit_and_model(100);
    op_and_model(core_isa_pkg::OP_ADD);
    op_and_model(core_isa_pkg::OP_DUP);
    op_and_model(core_isa_pkg::OP_SEND);
    lit_and_model(100);
    op_and_model(core_isa_pkg::OP_ADD);
    op_and_model(core_isa_pkg::OP_DUP);
    op_and_model(core_isa_pkg::OP_SEND);
    op_and_model(core_isa_pkg::OP_PUSHF);
    op_and_model(core_isa_pkg::OP_SEND);
    lit_and_model(50);
    op_and_model(core_isa_pkg::OP_SUB);
    op_and_model(core_isa_pkg::OP_DUP);
    op_and_model(core_isa_pkg::OP_SEND);
    op_and_model(core_isa_pkg::OP_PUSHF);
    op_and_model(core_isa_pkg::OP_SEND);
    lit_and_model(5);
    op_and_model(core_isa_pkg::OP_XOR);
    op_and_model(core_isa_pkg::OP_DUP);
    op_and_model(core_isa_pkg::OP_SEND);
    // Carry left by the borrow above feeds ADDC
    lit_and_model(3);
    lit_and_model(4);
    op_and_model(core_isa_pkg::OP_ADDC);
    op_and_model(core_isa_pkg::OP_SEND);
    op_and_model(core_isa_pkg::OP_PUSHF);
    op_and_model(core_isa_pkg::OP_SEND);
    halt_here();
    release_reset();
    finish_test();
  endtask

  task automatic shuffle_test();
    begin_test("stack shuffles");
    lit_and_model(1);
    lit_and_model(2);
    lit_and_model(3);
    op_and_model(core_isa_pkg::OP_SWAP);
    op_and_model(core_isa_pkg::OP_SEND);
    op_and_model(core_isa_pkg::OP_DUP);
    op_and_model(core_isa_pkg::OP_SEND);
    op_and_model(core_isa_pkg::OP_SEND);
    op_and_model(core_isa_pkg::OP_SEND);
    lit_and_model(7);
    lit_and_model(8);
    op_and_model(core_isa_pkg::OP_DROP);
    op_and_model(core_isa_pkg::OP_SEND);
    halt_here();
    release_reset();
    finish_test();
  endtask

  task automatic call_test();
    begin_test("call and return");
    for (int k = 0; k < 3; k++) begin
      lit(10 + k);
      op(core_isa_pkg::OP_SEND);
      if (k < 2) begin
        lit(40);
        op(core_isa_pkg::OP_CALL);
      end
    end
    halt_here();
    // Outer routine sends 20, calls the inner one, then sends 21
    org(40);
    lit(20);
    op(core_isa_pkg::OP_SEND);
    lit(50);
    op(core_isa_pkg::OP_CALL);
    lit(21);
    op(core_isa_pkg::OP_SEND);
    op(core_isa_pkg::OP_RET);
    org(50);
    lit(30);
    op(core_isa_pkg::OP_SEND);
    op(core_isa_pkg::OP_RET);
    for (int k = 0; k < 3; k++) begin
      expect_send(8'(10 + k));
      if (k < 2) begin
        expect_send(8'd20);
        expect_send(8'd30);
        expect_send(8'd21);
      end
    end
    release_reset();
    finish_test();
  endtask

  task automatic loop_test();
    begin_test("counted loops");
    // Single loop, body 3..4
    lit(5);
    lit(4);
    op(core_isa_pkg::OP_LOOP);
    op(core_isa_pkg::OP_IDX);
    op(core_isa_pkg::OP_SEND);
    // Outer loop body 8..14, inner loop body 11..12
    lit(2);
    lit(14);
    op(core_isa_pkg::OP_LOOP);
    lit(3);
    lit(12);
    op(core_isa_pkg::OP_LOOP);
    op(core_isa_pkg::OP_IDX);
    op(core_isa_pkg::OP_SEND);
    op(core_isa_pkg::OP_IDX);
    op(core_isa_pkg::OP_SEND);
    // Body 18..24 jumps into a table indexed by the loop index
    lit(5);
    lit(24);
    op(core_isa_pkg::OP_LOOP);
    op(core_isa_pkg::OP_IDX);
    op(core_isa_pkg::OP_SEND);
    op(core_isa_pkg::OP_IDX);
    lit(60);
    op(core_isa_pkg::OP_ADD);
    op(core_isa_pkg::OP_JMP);
    op(core_isa_pkg::OP_NOP);
    halt_here();
    org(60);
    op(core_isa_pkg::OP_CONTINUE);
    op(core_isa_pkg::OP_CONTINUE);
    op(core_isa_pkg::OP_BREAK);
    for (int i = 0; i < 5; i++) expect_send(8'(i));
    for (int o = 0; o < 2; o++) begin
      for (int i = 0; i < 3; i++) expect_send(8'(i));
      expect_send(8'(o));
    end
    for (int i = 0; i <= 2; i++) expect_send(8'(i));
    release_reset();
    finish_test();
  endtask

  task automatic interrupt_test();
    begin_test("interrupts");
    lit(6);
    op(core_isa_pkg::OP_SETIE);
    lit(77);
    op(core_isa_pkg::OP_SEND);
    op(core_isa_pkg::OP_WAIT);
    lit(78);
    op(core_isa_pkg::OP_SEND);
    halt_here();
    // Every handler sends its own line number
    for (int l = 0; l < 3; l++) begin
      org(`CORE_VECTOR_BASE + l * `CORE_VECTOR_STRIDE);
      lit(l);
      op(core_isa_pkg::OP_SEND);
      op(core_isa_pkg::OP_RET);
    end
    expect_send(8'd77);
    expect_send(8'd1);
    expect_send(8'd78);
    release_reset();
    wait_strobe("main line send");
    // Line 0 is disabled, so WAIT keeps stalling while it is high alone
    irq_lines = 4'b0001;
    repeat (4) @(posedge clk);
    #2;
    irq_lines = 4'b0111;
    wait_strobe("handler send");
    irq_lines = '0;
    finish_test();
  endtask

  task automatic recv_test();
    int gap;
    begin_test("wait and receive");
    lit(4);
    op(core_isa_pkg::OP_SETIE);
    op(core_isa_pkg::OP_RECV);
    op(core_isa_pkg::OP_SEND);
    halt_here();
    org(`CORE_VECTOR_BASE + 2 * `CORE_VECTOR_STRIDE);
    lit(9);
    op(core_isa_pkg::OP_SEND);
    op(core_isa_pkg::OP_RET);
    expect_send(8'd2);
    gap = 5 + int'((next_rand() >> 16) % 8);
    release_reset();
    repeat (gap) @(posedge clk);
    #2;
    irq_lines = 4'b0100;
    @(posedge clk);
    #2;
    irq_lines = '0;
    finish_test();
  endtask

  initial begin
    reset = 1'b1;
    irq_lines = '0;
    arith_test();
    shuffle_test();
    call_test();
    loop_test();
    interrupt_test();
    recv_test();
    $display("Tests run %0d, passed %0d, failed %0d",
             tests_passed + tests_failed, tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0 && uut.chk.failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
core_isa_pkg.sv
core_uarch_pkg.sv
data_stack.sv
alu.sv
frame_stack.sv
loop_control.sv
interrupt_select.sv
core0.sv
core0_assertions.sv
tb_core0.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core0 testbench with Verilator

verilator --binary --timing --assert -Wno-fatal --top-module tb_core0 \
  -f files.f -o sim_core0
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_core0 +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1
